// File: apogeo_pkg.sv
package apogeo_pkg;

    // Bus geometry. Addresses are byte addresses and data moves a full word at a time.
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0] data_word_t;  // Write data, register contents, read data.

    // Every device owns 16 bytes, so the low 4 address bits select inside a region.
    localparam int REGION_OFFSET_BITS = 4;

    localparam logic [ADDR_WIDTH-1:0] TIMER_BASE = 32'h0000_8000;
    localparam logic [ADDR_WIDTH-1:0] GPIO_BASE  = 32'h0000_8010;

    // Device targeted by an access. DEV_NONE covers unmapped and misaligned accesses.
    typedef enum logic [1:0] {
        DEV_NONE  = 2'd0,
        DEV_TIMER = 2'd1,
        DEV_GPIO  = 2'd2
    } device_t;

    // Word index inside a region, taken from address bits 3 to 2.
    typedef logic [1:0] reg_index_t;

    // Timer register map.
    localparam reg_index_t TIMER_COMPARE_LOW  = 2'd0;
    localparam reg_index_t TIMER_COMPARE_HIGH = 2'd1;
    localparam reg_index_t TIMER_VALUE_LOW    = 2'd2;
    localparam reg_index_t TIMER_VALUE_HIGH   = 2'd3;

    // I/O port register map.
    localparam reg_index_t GPIO_OUT       = 2'd0;
    localparam reg_index_t GPIO_IN        = 2'd1;  // Read-only, writes are dropped.
    localparam reg_index_t GPIO_RISE_MASK = 2'd2;
    localparam reg_index_t GPIO_PENDING   = 2'd3;  // Write one to clear.

    localparam int GPIO_WIDTH = 8;  // Number of I/O pins.

endpackage : apogeo_pkg

// File: peripheral_decoder.sv
`timescale 1ns/10ps

module peripheral_decoder import apogeo_pkg::*; (
    input  logic                  read_i,
    input  logic                  write_i,
    input  logic [ADDR_WIDTH-1:0] address_i,

    output logic                  timer_write_o,
    output logic                  gpio_write_o,
    output logic                  access_o,
    output logic                  access_error_o,
    output reg_index_t            reg_index_o,
    output device_t               read_device_o
);

    logic timer_hit;   // Address falls inside the timer region.
    logic gpio_hit;    // Address falls inside the I/O region.
    logic misaligned;  // Byte offset inside the word is not zero.
    logic valid_addr;  // Mapped and word aligned.

    // A region matches when all bits above the 16-byte offset agree with its base.
    assign timer_hit = (address_i[ADDR_WIDTH-1:REGION_OFFSET_BITS] ==
                        TIMER_BASE[ADDR_WIDTH-1:REGION_OFFSET_BITS]);
    assign gpio_hit  = (address_i[ADDR_WIDTH-1:REGION_OFFSET_BITS] ==
                        GPIO_BASE[ADDR_WIDTH-1:REGION_OFFSET_BITS]);

    assign misaligned = |address_i[1:0];                        // Only whole words exist.
    assign valid_addr = (timer_hit | gpio_hit) & ~misaligned;

    assign access_o = read_i | write_i;  // Any strobe earns a response.

    // The error flag only matters while a strobe is present.
    assign access_error_o = access_o & ~valid_addr;

    // Write strobes stay low for an erroring access, so nothing is modified.
    assign timer_write_o = write_i & timer_hit & ~misaligned;
    assign gpio_write_o  = write_i & gpio_hit & ~misaligned;

    // The word index is shared by both peripherals.
    assign reg_index_o = address_i[3:2];

    // Pick the device whose read port feeds the result stage.
    always_comb begin
        read_device_o = DEV_NONE;  // Unmapped or misaligned.
        if (valid_addr) begin
            if (timer_hit) begin
                read_device_o = DEV_TIMER;
            end else begin
                read_device_o = DEV_GPIO;  // The only other mapped region.
            end
        end
    end

endmodule : peripheral_decoder

// File: timer.sv
`timescale 1ns/10ps

module timer import apogeo_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,

    // Write side.
    input  logic       write_i,
    input  data_word_t write_data_i,
    input  reg_index_t write_index_i,

    // Read side.
    input  reg_index_t read_index_i,
    output data_word_t read_data_o,

    output logic       timer_interrupt_o
);

    logic [1:0][DATA_WIDTH-1:0] compare_q;  // Match value, word 0 is the low half.
    logic [1:0][DATA_WIDTH-1:0] count_q;    // Free-running counter, same layout.

    // True when the current write targets the given register.
    function automatic logic write_hit(input reg_index_t index);
        return write_i && (write_index_i == index);
    endfunction : write_hit

    // Compare words reset to all ones so no match can happen right after reset.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            compare_q <= '1;
        end else begin
            if (write_hit(TIMER_COMPARE_LOW)) begin
                compare_q[0] <= write_data_i;
            end
            if (write_hit(TIMER_COMPARE_HIGH)) begin
                compare_q[1] <= write_data_i;
            end
        end
    end

    // A load of either word wins over counting for that cycle.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (write_hit(TIMER_VALUE_LOW)) begin
            count_q[0] <= write_data_i;  // High word keeps its value.
        end else if (write_hit(TIMER_VALUE_HIGH)) begin
            count_q[1] <= write_data_i;
        end else if (!timer_interrupt_o) begin
            count_q <= count_q + 1'b1;   // Carry runs across both words.
        end
        // Once the counter equals compare it stays there until one side is rewritten.
    end

    // The interrupt is a pure comparison, so a rewrite clears it on the next edge.
    assign timer_interrupt_o = (count_q == compare_q);

    always_comb begin
        case (read_index_i)
            TIMER_COMPARE_LOW:  read_data_o = compare_q[0];
            TIMER_COMPARE_HIGH: read_data_o = compare_q[1];
            TIMER_VALUE_LOW:    read_data_o = count_q[0];
            TIMER_VALUE_HIGH:   read_data_o = count_q[1];
            default:            read_data_o = '0;
        endcase
    end

endmodule : timer

// File: gpio_port.sv
`timescale 1ns/10ps

module gpio_port import apogeo_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Register write side.
    input  logic                  write_i,
    input  data_word_t            write_data_i,
    input  reg_index_t            write_index_i,

    // Register read side.
    input  reg_index_t            read_index_i,
    output data_word_t            read_data_o,

    // Pins.
    input  logic [GPIO_WIDTH-1:0] gpio_in_i,
    output logic [GPIO_WIDTH-1:0] gpio_out_o,
    output logic                  gpio_interrupt_o
);

    logic [GPIO_WIDTH-1:0] out_q;      // Output register driving the pins.
    logic [GPIO_WIDTH-1:0] mask_q;     // Bits allowed to raise a pending flag.
    logic [GPIO_WIDTH-1:0] pending_q;  // Sticky rising-edge flags.

    logic [GPIO_WIDTH-1:0] sync1_q;    // First synchroniser stage, may be metastable.
    logic [GPIO_WIDTH-1:0] sync2_q;    // Second stage, safe to use.
    logic [GPIO_WIDTH-1:0] prev_q;     // sync2_q one cycle earlier.

    logic [GPIO_WIDTH-1:0] rise;       // Masked rising edges this cycle.
    logic [GPIO_WIDTH-1:0] clear;      // Bits the bus asks to clear.

    // Pin inputs cross into the clock domain through two flops.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;  // Kept for edge detection.
        end
    end

    // A bit rises when it was low last cycle and is high now.
    assign rise = sync2_q & ~prev_q & mask_q;

    assign clear = (write_i && (write_index_i == GPIO_PENDING)) ?
                   write_data_i[GPIO_WIDTH-1:0] : '0;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_q     <= '0;
            mask_q    <= '0;
            pending_q <= '0;
        end else begin
            if (write_i && (write_index_i == GPIO_OUT)) begin
                out_q <= write_data_i[GPIO_WIDTH-1:0];
            end
            if (write_i && (write_index_i == GPIO_RISE_MASK)) begin
                mask_q <= write_data_i[GPIO_WIDTH-1:0];
            end
            // Clear first, then set, so a fresh edge survives a same-cycle clear.
            pending_q <= (pending_q & ~clear) | rise;
        end
    end

    assign gpio_out_o       = out_q;
    assign gpio_interrupt_o = |pending_q;  // Level stays up until software clears all bits.

    // Registers are narrower than the bus, the rest reads as zero.
    always_comb begin
        read_data_o = '0;
        case (read_index_i)
            GPIO_OUT:       read_data_o[GPIO_WIDTH-1:0] = out_q;
            GPIO_IN:        read_data_o[GPIO_WIDTH-1:0] = sync2_q;
            GPIO_RISE_MASK: read_data_o[GPIO_WIDTH-1:0] = mask_q;
            GPIO_PENDING:   read_data_o[GPIO_WIDTH-1:0] = pending_q;
            default:        read_data_o = '0;
        endcase
    end

endmodule : gpio_port

// File: read_return.sv
`timescale 1ns/10ps

module read_return import apogeo_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,

    // Access summary from the decoder.
    input  logic       access_i,
    input  logic       access_error_i,
    input  device_t    read_device_i,

    // Combinational read ports of the peripherals.
    input  data_word_t timer_data_i,
    input  data_word_t gpio_data_i,

    output data_word_t read_data_o,
    output logic       response_o,
    output logic       error_o
);

    data_word_t selected;  // Data of the addressed register in this cycle.
    data_word_t data_q;    // Data returned in the response cycle.
    logic       response_q;
    logic       error_q;

    always_comb begin
        case (read_device_i)
            DEV_TIMER: selected = timer_data_i;
            DEV_GPIO:  selected = gpio_data_i;
            default:   selected = '0;  // Unmapped accesses read as zero.
        endcase
    end

    // One response pulse follows every strobe by exactly one cycle.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            response_q <= 1'b0;
            error_q    <= 1'b0;
        end else begin
            response_q <= access_i;
            error_q    <= access_i & access_error_i;
        end
    end

    // Data is only captured on an access and holds between accesses.
    always_ff @(posedge clk_i) begin
        if (access_i) begin
            data_q <= access_error_i ? '0 : selected;
        end
    end

    assign read_data_o = data_q;
    assign response_o  = response_q;
    assign error_o     = error_q;

endmodule : read_return

// File: io_subsystem.sv
`timescale 1ns/10ps

module io_subsystem import apogeo_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Core bus port.
    input  logic                  read_i,
    input  logic                  write_i,
    input  logic [ADDR_WIDTH-1:0] address_i,
    input  data_word_t            write_data_i,
    output data_word_t            read_data_o,
    output logic                  response_o,
    output logic                  error_o,

    // Interrupt lines, routed out separately.
    output logic                  timer_interrupt_o,
    output logic                  gpio_interrupt_o,

    // I/O pins.
    input  logic [GPIO_WIDTH-1:0] gpio_in_i,
    output logic [GPIO_WIDTH-1:0] gpio_out_o
);

    logic       timer_write;   // Write strobe for the timer.
    logic       gpio_write;    // Write strobe for the I/O port.
    logic       access;        // Any read or write this cycle.
    logic       access_error;  // Unmapped or misaligned.
    reg_index_t reg_index;     // Shared register index.
    device_t    read_device;   // Device selected for read data.
    data_word_t timer_data;
    data_word_t gpio_data;

    peripheral_decoder u_decoder (
        .read_i         (read_i),
        .write_i        (write_i),
        .address_i      (address_i),
        .timer_write_o  (timer_write),
        .gpio_write_o   (gpio_write),
        .access_o       (access),
        .access_error_o (access_error),
        .reg_index_o    (reg_index),
        .read_device_o  (read_device)
    );

    // Both peripherals see the same index for writing and reading.
    timer u_timer (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .write_i           (timer_write),
        .write_data_i      (write_data_i),
        .write_index_i     (reg_index),
        .read_index_i      (reg_index),
        .read_data_o       (timer_data),
        .timer_interrupt_o (timer_interrupt_o)
    );

    gpio_port u_gpio (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .write_i          (gpio_write),
        .write_data_i     (write_data_i),
        .write_index_i    (reg_index),
        .read_index_i     (reg_index),
        .read_data_o      (gpio_data),
        .gpio_in_i        (gpio_in_i),
        .gpio_out_o       (gpio_out_o),
        .gpio_interrupt_o (gpio_interrupt_o)
    );

    read_return u_return (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .access_i       (access),
        .access_error_i (access_error),
        .read_device_i  (read_device),
        .timer_data_i   (timer_data),
        .gpio_data_i    (gpio_data),
        .read_data_o    (read_data_o),
        .response_o     (response_o),
        .error_o        (error_o)
    );

endmodule : io_subsystem

// File: tb_io_subsystem.sv
`timescale 1ns/10ps

module tb_io_subsystem import apogeo_pkg::*; ();

    logic                  clk_i = 1'b0;
    logic                  rst_n_i;
    logic                  read_i;
    logic                  write_i;
    logic [ADDR_WIDTH-1:0] address_i;
    data_word_t            write_data_i;
    data_word_t            read_data_o;
    logic                  response_o;
    logic                  error_o;
    logic                  timer_interrupt_o;
    logic                  gpio_interrupt_o;
    logic [GPIO_WIDTH-1:0] gpio_in_i;
    logic [GPIO_WIDTH-1:0] gpio_out_o;

    // Parsed stimulus, one entry per operation line of the file.
    string       op_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] data_q[$];
    logic [31:0] exp_q[$];
    string       name_q[$];

    int error_count = 0;  // Failed checks so far.
    int check_count = 0;
    int line_count  = 0;  // Every line of the file, comments included.
    bit stim_loaded = 1'b0;

    io_subsystem DUT (.*);

    always #5 clk_i = ~clk_i;  // 10 ns period.

    // Compares one value and reports a mismatch with the test name.
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // Level of the interrupt line picked by the address column: 0 timer, 1 I/O port.
    function automatic logic irq_level(input logic [31:0] sel);
        return sel[0] ? gpio_interrupt_o : timer_interrupt_o;
    endfunction

    // One bus access. It is entered on a falling edge and leaves on a falling edge.
    task automatic bus_access(input logic rd, input logic wr, input logic [31:0] addr,
                              input logic [31:0] data, input string name,
                              input logic exp_err, input logic [31:0] exp_data);
        read_i       = rd;
        write_i      = wr;
        address_i    = addr;
        write_data_i = data;
        @(negedge clk_i);  // The strobe was seen at the rising edge in between.
        read_i  = 1'b0;
        write_i = 1'b0;
        check_value({name, " response"}, 32'd1, 32'(response_o));
        check_value({name, " error"}, 32'(exp_err), 32'(error_o));
        if (rd || exp_err) begin
            check_value(name, exp_data, read_data_o);  // Error accesses return zero.
        end
        if (wr && !exp_err && (addr == GPIO_BASE)) begin
            // Pins follow the low bits of the output register.
            check_value({name, " pins"}, 32'(data[GPIO_WIDTH-1:0]), 32'(gpio_out_o));
        end
        @(negedge clk_i);
        check_value({name, " single response"}, 32'd0, 32'(response_o));  // One pulse only.
    endtask

    // Waits up to a bound of cycles for an interrupt line to reach a level.
    task automatic wait_level(input logic [31:0] sel, input int bound,
                              input logic exp_level, input string name);
        int waited;
        waited = 0;
        while ((irq_level(sel) !== exp_level) && (waited < bound)) begin
            @(negedge clk_i);
            waited++;
        end
        check_value(name, 32'(exp_level), 32'(irq_level(sel)));
    endtask

    // Reads every operation line of the stimulus file into the queues.
    task automatic load_stimulus(output bit ok);
        int          fd;
        int          fields;
        string       line;
        string       op;
        string       name;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expected;
        ok = 1'b0;
        fd = $fopen("io_stim.txt", "r");
        if (fd == 0) begin
            $display("Stimulus file io_stim.txt could not be opened");
            error_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                line_count++;
                if ((line.len() > 0) && (line.getc(0) != "#")) begin
                    fields = $sscanf(line, "%s %h %h %h %s", op, addr, data, expected, name);
                    if (fields == 5) begin
                        op_q.push_back(op);
                        addr_q.push_back(addr);
                        data_q.push_back(data);
                        exp_q.push_back(expected);
                        name_q.push_back(name);
                    end
                end
            end
            $fclose(fd);
            ok = 1'b1;
        end
    endtask

    initial begin
        bit ok;
        rst_n_i      = 1'b0;
        read_i       = 1'b0;
        write_i      = 1'b0;
        address_i    = '0;
        write_data_i = '0;
        gpio_in_i    = '0;
        load_stimulus(ok);
        stim_loaded = ok;
        repeat (8) @(negedge clk_i);  // Eight rising edges with reset low.
        rst_n_i = 1'b1;
        // Pins and interrupt lines straight out of reset.
        check_value("reset_pins", 32'd0, 32'(gpio_out_o));
        check_value("reset_timer_line", 32'd0, 32'(timer_interrupt_o));
        check_value("reset_gpio_line", 32'd0, 32'(gpio_interrupt_o));
        // The first access starts on this same falling edge, so the counter still reads zero.
        foreach (op_q[i]) begin
            case (op_q[i])
                "W": bus_access(1'b0, 1'b1, addr_q[i], data_q[i], name_q[i], 1'b0, exp_q[i]);
                "R": bus_access(1'b1, 1'b0, addr_q[i], '0, name_q[i], 1'b0, exp_q[i]);
                "E": begin
                    // A non-zero data column turns the erroring access into a write.
                    if (data_q[i] != 0) begin
                        bus_access(1'b0, 1'b1, addr_q[i], data_q[i], name_q[i], 1'b1, exp_q[i]);
                    end else begin
                        bus_access(1'b1, 1'b0, addr_q[i], '0, name_q[i], 1'b1, exp_q[i]);
                    end
                end
                "P": gpio_in_i = data_q[i][GPIO_WIDTH-1:0];  // Pins change on this falling edge.
                "N": repeat (int'(data_q[i])) @(negedge clk_i);
                "I": wait_level(addr_q[i], int'(data_q[i]), exp_q[i][0], name_q[i]);
                default: begin
                    $display("Unknown operation %s on test %s", op_q[i], name_q[i]);
                    error_count++;
                end
            endcase
        end
        $display("Summary: %0d checks run, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog. The limit grows with the length of the stimulus file.
    initial begin
        wait (stim_loaded);
        repeat (line_count * 200) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles, the run did not finish", line_count * 200);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule : tb_io_subsystem

// File: io_stim.txt
# Columns: op address data expected name (hex numbers). W write, R read, E error access
# (write if data is non-zero, else read), P set pins, N idle data cycles, I wait data cycles for line addr (0 timer, 1 gpio)
R 00008008 00000000 00000000 reset_count_low
R 0000800C 00000000 00000000 reset_count_high
R 00008000 00000000 FFFFFFFF reset_compare_low
R 00008004 00000000 FFFFFFFF reset_compare_high
R 00008010 00000000 00000000 reset_gpio_out
R 00008018 00000000 00000000 reset_rise_mask
R 0000801C 00000000 00000000 reset_pending
I 00000000 00000000 00000000 reset_timer_irq
I 00000001 00000000 00000000 reset_gpio_irq
W 00008000 12345678 00000000 wr_compare_low
R 00008000 00000000 12345678 rd_compare_low
W 00008004 00000002 00000000 wr_compare_high
R 00008004 00000000 00000002 rd_compare_high
W 00008010 000000A5 00000000 wr_gpio_out
R 00008010 00000000 000000A5 rd_gpio_out
W 00008000 00001000 00000000 set_compare_low
W 00008004 00000001 00000000 set_compare_high
W 0000800C 00000001 00000000 set_count_high
W 00008008 00000FEC 00000000 set_count_low
I 00000000 00000028 00000001 timer_match_irq
R 00008008 00000000 00001000 count_holds_low_1
R 00008008 00000000 00001000 count_holds_low_2
R 0000800C 00000000 00000001 count_holds_high
I 00000000 00000000 00000001 timer_irq_still_high
W 00008000 00002000 00000000 rewrite_compare_low
I 00000000 00000002 00000000 timer_irq_dropped
W 00008018 00000005 00000000 set_rise_mask
P 00000000 00000007 00000000 drive_pins
N 00000000 00000005 00000000 settle_pins
R 0000801C 00000000 00000005 pending_both
I 00000001 00000000 00000001 gpio_irq_high
W 0000801C 00000001 00000000 clear_bit0
R 0000801C 00000000 00000004 pending_bit2
I 00000001 00000000 00000001 gpio_irq_still_high
W 0000801C 00000004 00000000 clear_bit2
R 0000801C 00000000 00000000 pending_empty
I 00000001 00000002 00000000 gpio_irq_dropped
R 00008014 00000000 00000007 gpio_in_pins
E 00009000 00000000 00000000 unmapped_read
E 00008020 DEADBEEF 00000000 unmapped_write
E 00008001 00000000 00000000 misaligned_read
E 00008012 0000005A 00000000 misaligned_write
R 00008000 00000000 00002000 compare_low_kept
R 00008010 00000000 000000A5 gpio_out_kept
R 00008018 00000000 00000005 rise_mask_kept

// File: vlog.f
apogeo_pkg.sv
peripheral_decoder.sv
timer.sv
gpio_port.sv
read_return.sv
io_subsystem.sv
tb_io_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the I/O subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_io_subsystem \
    -f vlog.f -o sim_io
./obj_dir/sim_io | tee sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
